//--- src.f
common/decode_pkg.sv
decoder/opcode_classifier.sv
decoder/addr_mode_decoder.sv
decoder/operand_assembler.sv
source/decoder.sv
bench/decoder_props.sv
bench/decoder_tb.sv

//--- Bender.yml
package:
  name: decoder

sources:
  - common/decode_pkg.sv
  - decoder/opcode_classifier.sv
  - decoder/addr_mode_decoder.sv
  - decoder/operand_assembler.sv
  - source/decoder.sv
  - target: test
    files:
      - bench/decoder_props.sv
      - bench/decoder_tb.sv

//--- bench/decoder_tb.sv
`default_nettype none

module decoder_tb import decode_pkg::*; ();
        timeunit 1ns;
        timeprecision 1ps;

        typedef struct packed {
                logic        bad;
                logic [4:0]  func;
                logic [3:0]  mode;
                logic [2:0]  sel_a;
                logic [2:0]  sel_b;
                logic [7:0]  imm;
                logic [15:0] addr;
                logic [31:0] cycle;
        } instr_t;

        localparam int N_GRP1   = 64;
        localparam int N_GRP2   = 48;
        localparam int N_DIRECT = 6;
        localparam int N_SPEC   = 4;
        localparam int N_ILL    = 40;
        localparam int N_MIX    = 300;
        localparam int MAX_GAP  = 5;
        localparam int N_INSTR  = N_GRP1 + N_GRP2 + N_DIRECT + 5 * N_SPEC + 2 * N_ILL + N_MIX;
        localparam int TIMEOUT  = 16 + N_INSTR * 3 * (MAX_GAP + 1) + 500;

        logic        clk;
        logic        reset_n;
        logic [7:0]  read;
        logic        byte_strobe;
        logic [4:0]  dec_func;
        logic [3:0]  addr_mode;
        logic [2:0]  reg_sel_a;
        logic [2:0]  reg_sel_b;
        logic [7:0]  imm;
        logic [15:0] addr;
        logic        instruct_ready;
        logic        illegal;

        instr_t      exp_q[$];
        instr_t      held = '0; // last legal instruction, zero after reset.
        instr_t      got;
        int          cycle = 0;
        int          errors = 0;
        int          err_mark = 0;
        int          prop_seen = 0;
        int          tests_run = 0;
        int          tests_failed = 0;
        logic        checking = 1'b0;
        logic [7:0]  specials [5] = '{8'hea, 8'he8, 8'hca, 8'h18, 8'h38};
        // asl a, ror a, ldx #imm, stx zpg,y, ldx zpg,y, ldx abs,y.
        logic [7:0]  group_two_cases [N_DIRECT] = '{8'h0a, 8'h6a, 8'ha2, 8'h96, 8'hb6, 8'hbe};

        decoder decoder_inst (
                .clk            (clk),
                .reset_n        (reset_n),
                .read           (read),
                .byte_strobe    (byte_strobe),
                .dec_func       (dec_func),
                .addr_mode      (addr_mode),
                .reg_sel_a      (reg_sel_a),
                .reg_sel_b      (reg_sel_b),
                .imm            (imm),
                .addr           (addr),
                .instruct_ready (instruct_ready),
                .illegal        (illegal)
        );

        always #20 clk = ~clk;

        always @(posedge clk) begin
                cycle = cycle + 1;
                if (cycle > TIMEOUT) begin
                        $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
                        $display("ERRORS FOUND");
                        $finish;
                end
        end

        task automatic check_value(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
                assert (act_v === exp_v) else begin
                        $display("Fail at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
                        errors++;
                end
        endtask

        // reference decode of one opcode byte.
        task automatic model_decode(input logic [7:0] op, output instr_t e, output int n);
                logic [2:0] aaa;
                logic [2:0] bbb;
                logic       xy;
                aaa = op[7:5];
                bbb = op[4:2];
                xy  = (aaa == 3'b100 || aaa == 3'b101);
                e = '0;
                e.func = {aaa, op[1:0]};
                e.mode = MODE_IMPLIED;
                case (op)
                        8'hea: e.func = FUNC_NOP;
                        8'h18: e.func = FUNC_CLC;
                        8'h38: e.func = FUNC_SEC;
                        8'he8: begin
                                e.func  = FUNC_INX;
                                e.sel_a = REG_X;
                        end
                        8'hca: begin
                                e.func  = FUNC_DEX;
                                e.sel_a = REG_X;
                        end
                        default: begin
                                if (op[1:0] == 2'b01) begin
                                        e.sel_a = REG_A;
                                        case (bbb)
                                                3'b000: e.mode = MODE_X_IND;
                                                3'b001: e.mode = MODE_ZPG;
                                                3'b010: e.mode = MODE_IMM;
                                                3'b011: e.mode = MODE_ABS;
                                                3'b100: e.mode = MODE_IND_Y;
                                                3'b101: e.mode = MODE_ZPG_X;
                                                3'b110: e.mode = MODE_ABS_Y;
                                                3'b111: e.mode = MODE_ABS_X;
                                        endcase
                                        e.bad = (e.func == FUNC_STA && e.mode == MODE_IMM);
                                end else if (op[1:0] == 2'b10) begin
                                        case (bbb)
                                                3'b000:  e.mode = MODE_IMM;
                                                3'b001:  e.mode = MODE_ZPG;
                                                3'b010:  e.mode = MODE_ACCUM;
                                                3'b011:  e.mode = MODE_ABS;
                                                3'b101:  e.mode = xy ? MODE_ZPG_Y : MODE_ZPG_X;
                                                3'b111:  e.mode = xy ? MODE_ABS_Y : MODE_ABS_X;
                                                default: e.bad = 1'b1;
                                        endcase
                                        e.sel_a = xy ? REG_X : (e.mode == MODE_ACCUM ? REG_A : REG_MEM);
                                        if (e.mode == MODE_IMM && e.func != FUNC_LDX)
                                                e.bad = 1'b1;
                                        if (e.mode == MODE_ACCUM && aaa[2])
                                                e.bad = 1'b1; // stx, ldx, dec, inc.
                                end else begin
                                        e.bad = 1'b1;
                                end
                        end
                endcase
                case (e.mode)
                        MODE_X_IND, MODE_ZPG_X, MODE_ABS_X: e.sel_b = REG_X;
                        MODE_IND_Y, MODE_ZPG_Y, MODE_ABS_Y: e.sel_b = REG_Y;
                        default:                            e.sel_b = REG_NONE;
                endcase
                case (e.mode)
                        MODE_IMPLIED, MODE_ACCUM:         n = 0;
                        MODE_ABS, MODE_ABS_X, MODE_ABS_Y: n = 2;
                        default:                          n = 1;
                endcase
        endtask

        task automatic send_byte(input logic [7:0] b, input int max_gap);
                int gap;
                gap = (max_gap > 0) ? $urandom_range(max_gap, 0) : 0;
                repeat (gap) begin
                        @(negedge clk);
                        byte_strobe = 1'b0;
                        read        = 8'($urandom); // noise while idle.
                end
                @(negedge clk);
                read        = b;
                byte_strobe = 1'b1;
        endtask

        task automatic send_instr(input logic [7:0] op, input int max_gap);
                instr_t     e;
                int         n;
                logic [7:0] lo;
                logic [7:0] hi;
                model_decode(op, e, n);
                lo = 8'($urandom);
                hi = 8'($urandom);
                send_byte(op, max_gap);
                if (!e.bad && n > 0)
                        send_byte(lo, max_gap);
                if (!e.bad && n > 1)
                        send_byte(hi, max_gap);
                if (e.mode == MODE_IMM)
                        e.imm = lo;
                else if (n == 1)
                        e.addr = {8'h00, lo};
                else if (n == 2)
                        e.addr = {hi, lo};
                e.cycle = cycle + 1; // pulse follows the edge after this drive.
                exp_q.push_back(e);
        endtask

        function automatic logic [7:0] rand_group_one();
                logic [7:0] op;
                do
                        op = {6'($urandom), 2'b01};
                while (op == 8'h89);
                return op;
        endfunction

        task automatic end_test(input string name);
                int prop_fails;
                @(negedge clk);
                byte_strobe = 1'b0;
                while (exp_q.size() != 0)
                        @(negedge clk);
                repeat (4) @(negedge clk);
                prop_fails = decoder_inst.assembler_inst.props_inst.failures;
                errors += prop_fails - prop_seen;
                prop_seen = prop_fails;
                tests_run++;
                if (errors == err_mark) begin
                        $display("test %s: passed", name);
                end else begin
                        tests_failed++;
                        $display("test %s: %0d errors", name, errors - err_mark);
                end
                err_mark = errors;
        endtask

        always @(negedge clk) begin
                if (checking) begin
                        if (instruct_ready || illegal) begin
                                assert (exp_q.size() != 0) else begin
                                        $display("%0t: output pulse with no instruction pending",
                                                 $time);
                                        errors++;
                                end
                                if (exp_q.size() != 0) begin
                                        got = exp_q.pop_front();
                                        check_value("illegal", got.bad, illegal);
                                        check_value("instruct_ready", !got.bad, instruct_ready);
                                        assert (cycle == got.cycle) else begin
                                                $display("Fail at %0t: pulse cycle expected %0d, got %0d",
                                                         $time, got.cycle, cycle);
                                                errors++;
                                        end
                                        if (!got.bad)
                                                held = got;
                                end
                        end
                        check_value("dec_func", held.func, dec_func);
                        check_value("addr_mode", held.mode, addr_mode);
                        check_value("reg_sel_a", held.sel_a, reg_sel_a);
                        check_value("reg_sel_b", held.sel_b, reg_sel_b);
                        check_value("imm", held.imm, imm);
                        check_value("addr", held.addr, addr);
                end
        end

        initial begin
                instr_t     e;
                int         n;
                logic [7:0] op;
                clk         = 1'b0;
                reset_n     = 1'b0;
                read        = 8'h00;
                byte_strobe = 1'b0;
                void'($urandom(32'he53f_e1fd));
                repeat (16) @(negedge clk);
                reset_n  = 1'b1;
                checking = 1'b1;
                repeat (8) @(negedge clk);
                end_test("reset");

                repeat (N_GRP1)
                        send_instr(rand_group_one(), 0);
                end_test("group one");

                foreach (group_two_cases[i])
                        send_instr(group_two_cases[i], 0);
                repeat (N_GRP2) begin
                        do begin
                                op = {6'($urandom), 2'b10};
                                model_decode(op, e, n);
                        end while (e.bad);
                        send_instr(op, 0);
                end
                end_test("group two");

                repeat (N_SPEC)
                        foreach (specials[i])
                                send_instr(specials[i], 0);
                end_test("implied specials");

                repeat (N_ILL) begin
                        do begin
                                op = 8'($urandom);
                                model_decode(op, e, n);
                        end while (!e.bad);
                        send_instr(op, 0);
                        send_instr(rand_group_one(), 0);
                end
                end_test("illegal opcodes");

                repeat (N_MIX)
                        send_instr(8'($urandom), MAX_GAP);
                end_test("strobe gaps");

                $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
                if (errors == 0)
                        $display("NO ERRORS");
                else
                        $display("ERRORS FOUND");
                $finish;
        end

endmodule

`default_nettype wire

//--- bench/decoder_props.sv
`default_nettype none

module decoder_props import decode_pkg::*; (
        input logic              clk,
        input logic              reset_n,
        input logic              byte_strobe,
        input logic              instruct_ready,
        input logic              illegal,
        input logic [4:0]        dec_func,
        input logic [3:0]        addr_mode,
        input logic [2:0]        reg_sel_a,
        input logic [2:0]        reg_sel_b,
        input logic [BYTE_W-1:0] imm,
        input logic [ADDR_W-1:0] addr
);
        timeunit 1ns;
        timeprecision 1ps;

        logic [38:0] held;
        int          failures = 0;

        assign held = {dec_func, addr_mode, reg_sel_a, reg_sel_b, imm, addr};

        no_overlap: assert property (@(posedge clk) disable iff (!reset_n)
                !(instruct_ready && illegal))
                else begin
                        $error("instruct_ready and illegal are high together");
                        failures++;
                end

        // each high cycle answers a byte taken on the edge before.
        ready_pulse: assert property (@(posedge clk) disable iff (!reset_n)
                instruct_ready |-> $past(byte_strobe))
                else begin
                        $error("instruct_ready is high with no byte taken on the edge before");
                        failures++;
                end

        illegal_pulse: assert property (@(posedge clk) disable iff (!reset_n)
                illegal |-> $past(byte_strobe))
                else begin
                        $error("illegal is high with no byte taken on the edge before");
                        failures++;
                end

        quiet_after_reset: assert property (@(posedge clk)
                !reset_n |=> !instruct_ready && !illegal)
                else begin
                        $error("a pulse follows a reset cycle");
                        failures++;
                end

        // held outputs only move together with the ready pulse.
        hold_outputs: assert property (@(posedge clk) disable iff (!reset_n)
                !$stable(held) |-> instruct_ready)
                else begin
                        $error("decoded outputs changed without instruct_ready");
                        failures++;
                end

endmodule

bind operand_assembler decoder_props props_inst (
        .clk            (clk),
        .reset_n        (reset_n),
        .byte_strobe    (byte_strobe),
        .instruct_ready (instruct_ready),
        .illegal        (illegal),
        .dec_func       (dec_func),
        .addr_mode      (addr_mode),
        .reg_sel_a      (reg_sel_a),
        .reg_sel_b      (reg_sel_b),
        .imm            (imm),
        .addr           (addr)
);

`default_nettype wire

//--- source/decoder.sv
`default_nettype none

module decoder import decode_pkg::*; (
        input  logic              clk,
        input  logic              reset_n,
        input  logic [BYTE_W-1:0] read,
        input  logic              byte_strobe,
        output logic [4:0]        dec_func,
        output logic [3:0]        addr_mode,
        output logic [2:0]        reg_sel_a,
        output logic [2:0]        reg_sel_b,
        output logic [BYTE_W-1:0] imm,
        output logic [ADDR_W-1:0] addr,
        output logic              instruct_ready,
        output logic              illegal
);

        opcode_u    opcode;
        logic [4:0] dec_func_next;
        logic [3:0] addr_mode_next;
        logic [2:0] reg_sel_a_next;
        logic [2:0] reg_sel_b_next;
        logic [1:0] operand_count;
        logic       legal;

        opcode_classifier classifier_inst (
                .opcode    (opcode),
                .dec_func  (dec_func_next),
                .reg_sel_a (reg_sel_a_next),
                .reg_sel_b (reg_sel_b_next),
                .legal     (legal)
        );

        addr_mode_decoder mode_inst (
                .opcode        (opcode),
                .addr_mode     (addr_mode_next),
                .operand_count (operand_count)
        );

        operand_assembler assembler_inst (
                .clk            (clk),
                .reset_n        (reset_n),
                .read           (read),
                .byte_strobe    (byte_strobe),
                .dec_func_next  (dec_func_next),
                .addr_mode_next (addr_mode_next),
                .reg_sel_a_next (reg_sel_a_next),
                .reg_sel_b_next (reg_sel_b_next),
                .operand_count  (operand_count),
                .legal          (legal),
                .opcode         (opcode),
                .dec_func       (dec_func),
                .addr_mode      (addr_mode),
                .reg_sel_a      (reg_sel_a),
                .reg_sel_b      (reg_sel_b),
                .imm            (imm),
                .addr           (addr),
                .instruct_ready (instruct_ready),
                .illegal        (illegal)
        );

endmodule

`default_nettype wire

//--- decoder/operand_assembler.sv
`default_nettype none

module operand_assembler import decode_pkg::*; (
        input  logic              clk,
        input  logic              reset_n,
        input  logic [BYTE_W-1:0] read,
        input  logic              byte_strobe,
        input  logic [4:0]        dec_func_next,
        input  logic [3:0]        addr_mode_next,
        input  logic [2:0]        reg_sel_a_next,
        input  logic [2:0]        reg_sel_b_next,
        input  logic [1:0]        operand_count,
        input  logic              legal,
        output opcode_u           opcode,
        output logic [4:0]        dec_func,
        output logic [3:0]        addr_mode,
        output logic [2:0]        reg_sel_a,
        output logic [2:0]        reg_sel_b,
        output logic [BYTE_W-1:0] imm,
        output logic [ADDR_W-1:0] addr,
        output logic              instruct_ready,
        output logic              illegal
);

        logic [1:0]        fetch_counter;
        logic [1:0]        fetch_target;
        logic              idle;
        logic              last_operand;
        logic [4:0]        pend_func;
        logic [3:0]        pend_mode;
        logic [2:0]        pend_sel_a;
        logic [2:0]        pend_sel_b;
        logic [BYTE_W-1:0] pend_lo;

        assign opcode       = read; // decoders look at the incoming byte.
        assign idle         = (fetch_counter == fetch_target);
        assign last_operand = (fetch_counter + 2'd1 == fetch_target);

        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        fetch_counter  <= 2'd0;
                        fetch_target   <= 2'd0;
                        instruct_ready <= 1'b0;
                        illegal        <= 1'b0;
                        dec_func       <= 5'd0;
                        addr_mode      <= MODE_IMPLIED;
                        reg_sel_a      <= REG_NONE;
                        reg_sel_b      <= REG_NONE;
                        imm            <= '0;
                        addr           <= '0;
                end else begin
                        instruct_ready <= 1'b0;
                        illegal        <= 1'b0;
                        if (byte_strobe && idle) begin
                                if (!legal) begin
                                        illegal <= 1'b1; // held outputs stay as they were.
                                end else if (operand_count == 2'd0) begin
                                        instruct_ready <= 1'b1;
                                        dec_func       <= dec_func_next;
                                        addr_mode      <= addr_mode_next;
                                        reg_sel_a      <= reg_sel_a_next;
                                        reg_sel_b      <= reg_sel_b_next;
                                        imm            <= '0;
                                        addr           <= '0;
                                end else begin
                                        fetch_counter <= 2'd0;
                                        fetch_target  <= operand_count;
                                end
                        end else if (byte_strobe) begin
                                fetch_counter <= fetch_counter + 2'd1;
                                if (last_operand) begin
                                        instruct_ready <= 1'b1;
                                        dec_func       <= pend_func;
                                        addr_mode      <= pend_mode;
                                        reg_sel_a      <= pend_sel_a;
                                        reg_sel_b      <= pend_sel_b;
                                        if (pend_mode == MODE_IMM) begin
                                                imm  <= read;
                                                addr <= '0;
                                        end else if (fetch_target == 2'd2) begin
                                                imm  <= '0;
                                                addr <= {read, pend_lo}; // high byte comes last.
                                        end else begin
                                                imm  <= '0;
                                                addr <= {{(ADDR_W-BYTE_W){1'b0}}, read};
                                        end
                                end
                        end
                end
        end

        // decoder results, sampled at the opcode byte.
        always_ff @(posedge clk) begin
                if (byte_strobe && idle) begin
                        pend_func  <= dec_func_next;
                        pend_mode  <= addr_mode_next;
                        pend_sel_a <= reg_sel_a_next;
                        pend_sel_b <= reg_sel_b_next;
                end
                if (byte_strobe && !idle && fetch_counter == 2'd0)
                        pend_lo <= read;
        end

endmodule

`default_nettype wire

//--- decoder/addr_mode_decoder.sv
`default_nettype none

module addr_mode_decoder import decode_pkg::*; (
        input  opcode_u    opcode,
        output logic [3:0] addr_mode,
        output logic [1:0] operand_count
);

        logic xy_swap;

        assign xy_swap = (opcode.grp.aaa[2:1] == 2'b10); // stx and ldx index with y.

        always_comb begin
                addr_mode = MODE_IMPLIED;
                if (!is_special(opcode)) begin
                        case (opcode.grp.cc)
                                2'b01: begin
                                        case (opcode.grp.bbb)
                                                3'b000: addr_mode = MODE_X_IND;
                                                3'b001: addr_mode = MODE_ZPG;
                                                3'b010: addr_mode = MODE_IMM;
                                                3'b011: addr_mode = MODE_ABS;
                                                3'b100: addr_mode = MODE_IND_Y;
                                                3'b101: addr_mode = MODE_ZPG_X;
                                                3'b110: addr_mode = MODE_ABS_Y;
                                                default: addr_mode = MODE_ABS_X;
                                        endcase
                                end
                                2'b10: begin
                                        case (opcode.grp.bbb)
                                                3'b000: addr_mode = MODE_IMM;
                                                3'b001: addr_mode = MODE_ZPG;
                                                3'b010: addr_mode = MODE_ACCUM;
                                                3'b011: addr_mode = MODE_ABS;
                                                3'b101: addr_mode = xy_swap ? MODE_ZPG_Y
                                                                            : MODE_ZPG_X;
                                                3'b111: addr_mode = xy_swap ? MODE_ABS_Y
                                                                            : MODE_ABS_X;
                                                default: addr_mode = MODE_IMPLIED;
                                        endcase
                                end
                                default: addr_mode = MODE_IMPLIED;
                        endcase
                end
        end

        always_comb begin
                case (addr_mode)
                        MODE_IMPLIED, MODE_ACCUM:        operand_count = 2'd0;
                        MODE_ABS, MODE_ABS_X, MODE_ABS_Y: operand_count = 2'd2;
                        default:                         operand_count = 2'd1;
                endcase
        end

endmodule

`default_nettype wire

//--- decoder/opcode_classifier.sv
`default_nettype none

module opcode_classifier import decode_pkg::*; (
        input  opcode_u    opcode,
        output logic [4:0] dec_func,
        output logic [2:0] reg_sel_a,
        output logic [2:0] reg_sel_b,
        output logic       legal
);

        logic xy_swap;

        assign xy_swap = (opcode.grp.aaa[2:1] == 2'b10); // stx and ldx.

        always_comb begin
                dec_func  = {opcode.grp.aaa, opcode.grp.cc};
                reg_sel_a = REG_NONE;
                reg_sel_b = REG_NONE;
                legal     = 1'b0;

                if (is_special(opcode)) begin
                        legal = 1'b1;
                        case (opcode.grid.col)
                                4'h8: begin
                                        case (opcode.grid.row)
                                                4'h1:    dec_func = FUNC_CLC;
                                                4'h3:    dec_func = FUNC_SEC;
                                                default: begin
                                                        dec_func  = FUNC_INX;
                                                        reg_sel_a = REG_X;
                                                end
                                        endcase
                                end
                                default: begin
                                        if (opcode.grid.row == 4'hc) begin
                                                dec_func  = FUNC_DEX;
                                                reg_sel_a = REG_X;
                                        end else begin
                                                dec_func  = FUNC_NOP;
                                        end
                                end
                        endcase
                end else begin
                        case (opcode.grp.cc)
                                2'b01: begin
                                        reg_sel_a = REG_A;
                                        legal     = !(dec_func == FUNC_STA &&
                                                      opcode.grp.bbb == 3'b010); // no sta #imm.
                                        case (opcode.grp.bbb)
                                                3'b000, 3'b101, 3'b111: reg_sel_b = REG_X;
                                                3'b100, 3'b110:         reg_sel_b = REG_Y;
                                                default:                reg_sel_b = REG_NONE;
                                        endcase
                                end
                                2'b10: begin
                                        if (xy_swap)
                                                reg_sel_a = REG_X;
                                        else if (opcode.grp.bbb == 3'b010)
                                                reg_sel_a = REG_A; // shift on accumulator.
                                        else
                                                reg_sel_a = REG_MEM;
                                        if (opcode.grp.bbb == 3'b101 || opcode.grp.bbb == 3'b111)
                                                reg_sel_b = xy_swap ? REG_Y : REG_X;
                                        case (opcode.grp.bbb)
                                                3'b000:         legal = (dec_func == FUNC_LDX);
                                                3'b010:         legal = !opcode.grp.aaa[2];
                                                3'b100, 3'b110: legal = 1'b0;
                                                default:        legal = 1'b1;
                                        endcase
                                end
                                default: legal = 1'b0; // cc 00 and 11 outside the specials.
                        endcase
                end
        end

endmodule

`default_nettype wire

//--- common/decode_pkg.sv
`default_nettype none

package decode_pkg;

        localparam int BYTE_W = 8;
        localparam int ADDR_W = 16;

        // one opcode byte, read either as group fields or as a hex grid position.
        typedef union packed {
                struct packed {
                        logic [2:0] aaa;
                        logic [2:0] bbb;
                        logic [1:0] cc;
                } grp;
                struct packed {
                        logic [3:0] row;
                        logic [3:0] col;
                } grid;
        } opcode_u;

        // group one, {aaa, cc} with cc = 01.
        localparam logic [4:0] FUNC_ORA = 5'b000_01;
        localparam logic [4:0] FUNC_AND = 5'b001_01;
        localparam logic [4:0] FUNC_EOR = 5'b010_01;
        localparam logic [4:0] FUNC_ADC = 5'b011_01;
        localparam logic [4:0] FUNC_STA = 5'b100_01;
        localparam logic [4:0] FUNC_LDA = 5'b101_01;
        localparam logic [4:0] FUNC_CMP = 5'b110_01;
        localparam logic [4:0] FUNC_SBC = 5'b111_01;

        // group two, {aaa, cc} with cc = 10.
        localparam logic [4:0] FUNC_ASL = 5'b000_10;
        localparam logic [4:0] FUNC_ROL = 5'b001_10;
        localparam logic [4:0] FUNC_LSR = 5'b010_10;
        localparam logic [4:0] FUNC_ROR = 5'b011_10;
        localparam logic [4:0] FUNC_STX = 5'b100_10;
        localparam logic [4:0] FUNC_LDX = 5'b101_10;
        localparam logic [4:0] FUNC_DEC = 5'b110_10;
        localparam logic [4:0] FUNC_INC = 5'b111_10;

        // implied specials live in the unused cc = 11 space.
        localparam logic [4:0] FUNC_NOP = 5'b000_11;
        localparam logic [4:0] FUNC_INX = 5'b001_11;
        localparam logic [4:0] FUNC_DEX = 5'b010_11;
        localparam logic [4:0] FUNC_CLC = 5'b011_11;
        localparam logic [4:0] FUNC_SEC = 5'b100_11;

        localparam logic [3:0] MODE_IMPLIED = 4'd0;
        localparam logic [3:0] MODE_ACCUM   = 4'd1;
        localparam logic [3:0] MODE_IMM     = 4'd2;
        localparam logic [3:0] MODE_ZPG     = 4'd3;
        localparam logic [3:0] MODE_ZPG_X   = 4'd4;
        localparam logic [3:0] MODE_ZPG_Y   = 4'd5;
        localparam logic [3:0] MODE_ABS     = 4'd6;
        localparam logic [3:0] MODE_ABS_X   = 4'd7;
        localparam logic [3:0] MODE_ABS_Y   = 4'd8;
        localparam logic [3:0] MODE_X_IND   = 4'd9;
        localparam logic [3:0] MODE_IND_Y   = 4'd10;

        localparam logic [2:0] REG_NONE = 3'd0;
        localparam logic [2:0] REG_A    = 3'd1;
        localparam logic [2:0] REG_X    = 3'd2;
        localparam logic [2:0] REG_Y    = 3'd3;
        localparam logic [2:0] REG_MEM  = 3'd4;

        // specials sit in columns 8 and a: clc 18, sec 38, inx e8, dex ca, nop ea.
        function automatic logic is_special(opcode_u op);
                case (op.grid.col)
                        4'h8:    return op.grid.row inside {4'h1, 4'h3, 4'he};
                        4'ha:    return op.grid.row inside {4'hc, 4'he};
                        default: return 1'b0;
                endcase
        endfunction

endpackage

`default_nettype wire
